// ==== Bender.yml ====
package:
  name: surf_merger

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/surf_pkg.sv
      - src/axis_if.sv
      - src/surf_combiner.sv
      - src/surf_reducer.sv
      - src/surf_merger.sv

  - target: test
    include_dirs:
      - src
    files:
      - tests/surf_merger_tb.sv

// ==== src/axis_if.sv ====
`timescale 1ns/1ps

// minimal AXI4-Stream link with a packet marker.
// a transfer happens on a rising clock edge where tvalid and tready
// are both high, and the source holds tvalid, tdata and tlast
// stable until then
interface axis_if #(
    parameter int width = 32
);

    logic [width-1:0] tdata;
    logic             tvalid;
    logic             tready;
    logic             tlast;

    // the side that produces data
    modport source (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    // the side that consumes data
    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

endinterface

// ==== src/surf_combiner.sv ====
`timescale 1ns/1ps
`include "surf_consts.svh"

// joins the seven sector byte lanes into one registered 64-bit beat.
// all lanes are taken together in one cycle, so no sector byte
// ever leaves without its partners from the other sectors
module surf_combiner (
    input  logic                                      aclk,
    input  logic                                      arst_n,
    input  surf_pkg::surf_byte_t [`SURF_LANES-1:0]    s_tdata,
    input  logic                 [`SURF_LANES-1:0]    s_tvalid,
    output logic                 [`SURF_LANES-1:0]    s_tready,
    input  logic                 [`SURF_LANES-1:0]    s_tlast,
    axis_if.source                                    ev64
);

    import surf_pkg::*;

    // byte lanes in one beat, including the reserved one at the top
    localparam int beat_bytes = `SURF_WIDE_W / `SURF_BYTE_W;

    logic     all_valid;
    logic     load;
    logic     full_q;
    logic     last_q;
    ev_beat_u beat_q;

    // nothing moves until every sector has a byte waiting
    assign all_valid = &s_tvalid;

    // the output register can take a new beat when it is empty, or
    // when the beat it holds leaves in this same cycle
    assign load = all_valid && (!full_q || ev64.tready);

    // one common ready for every lane
    assign s_tready = {`SURF_LANES{load}};

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (ev64.tready) begin
            full_q <= 1'b0;
        end
    end

    // payload register, filled through the byte view of the beat.
    // lanes above the last sector are the reserved path and read zero
    always_ff @(posedge aclk) begin
        if (load) begin
            for (int i = 0; i < beat_bytes; i++) begin
                if (i < `SURF_LANES) begin
                    beat_q.bytes[i] <= s_tdata[i];
                end else begin
                    beat_q.bytes[i] <= '0;
                end
            end
            // packet boundaries follow sector 0 only
            last_q <= s_tlast[0];
        end
    end

    assign ev64.tdata  = beat_q;
    assign ev64.tvalid = full_q;
    assign ev64.tlast  = last_q;

    // a stalled beat must not change under the reducer
    property p_beat_held;
        @(posedge aclk) disable iff (!arst_n)
        ev64.tvalid && !ev64.tready |=>
            ev64.tvalid && $stable(ev64.tdata) && $stable(ev64.tlast);
    endproperty

    a_beat_held : assert property (p_beat_held)
        else $error("combiner beat changed while stalled");

    // no lane is ever acknowledged alone
    property p_ready_needs_all_valid;
        @(posedge aclk) disable iff (!arst_n)
        (|s_tready) |-> (&s_tvalid);
    endproperty

    a_ready_needs_all_valid : assert property (p_ready_needs_all_valid)
        else $error("sector ready raised while a lane was not valid");

endmodule

// ==== src/surf_consts.svh ====
`ifndef SURF_CONSTS_SVH
`define SURF_CONSTS_SVH

// number of sector readout units feeding the merger
`define SURF_LANES 7

// width of one sector byte lane
`define SURF_BYTE_W 8

// width of the combined beat, one byte per lane plus the reserved lane
`define SURF_WIDE_W 64

// width of the output event word
`define SURF_NARROW_W 32

// the wide beat must hold every sector lane plus the reserved one
// and it must split into a whole number of output words.
// with the values above that is 8 byte lanes and 2 words per beat

`endif

// ==== src/surf_merger.sv ====
`timescale 1ns/1ps
`include "surf_consts.svh"

// event merging path of the readout board.
// seven sector byte streams are joined into one 64-bit beat,
// then each beat goes out as two 32-bit words on one stream.
// the eighth byte of the beat is reserved for a path that
// does not exist yet and is filled with zero in the combiner
module surf_merger (
    input  logic                                      aclk,
    input  logic                                      arst_n,

    // sector inputs, index i is sector i
    input  surf_pkg::surf_byte_t [`SURF_LANES-1:0]    s_tdata,
    input  logic                 [`SURF_LANES-1:0]    s_tvalid,
    output logic                 [`SURF_LANES-1:0]    s_tready,
    input  logic                 [`SURF_LANES-1:0]    s_tlast,

    // merged event output
    output surf_pkg::ev_word_t                        m_tdata,
    output logic                                      m_tvalid,
    input  logic                                      m_tready,
    output logic                                      m_tlast
);

    // wide link between the two stages
    axis_if #(
        .width (`SURF_WIDE_W)
    ) ev64 ();

    // collect one byte from every sector into one beat.
    // sector 0 alone decides where packets end
    surf_combiner u_combiner (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .ev64     (ev64.source)
    );

    // LSB first, so going 64 to 32 gives sectors 3..0 then
    // the reserved byte above sectors 6..4
    surf_reducer u_reducer (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .ev64     (ev64.sink),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast)
    );

endmodule

// ==== src/surf_pkg.sv ====
`include "surf_consts.svh"

package surf_pkg;

    // one byte from one sector
    typedef logic [`SURF_BYTE_W-1:0] surf_byte_t;

    // one word on the output stream
    typedef logic [`SURF_NARROW_W-1:0] ev_word_t;

    // the 64-bit beat is written by lane and read by half.
    // AXI4-Stream is LSB first, so byte 0 is sector 0 and
    // half 0 carries sectors 3..0 while half 1 carries the
    // reserved lane above sectors 6..4
    typedef union packed {
        // byte view, index i is sector i, the top index is the reserved lane
        surf_byte_t [`SURF_WIDE_W/`SURF_BYTE_W-1:0] bytes;
        // half view, index 0 is bytes 3..0 and index 1 is bytes 7..4
        ev_word_t [`SURF_WIDE_W/`SURF_NARROW_W-1:0] halves;
    } ev_beat_u;

endpackage

// ==== src/surf_reducer.sv ====
`timescale 1ns/1ps

// splits each 64-bit beat into two 32-bit words, half 0 first.
// a new beat is taken in the cycle that half 1 leaves, so the
// output can stay busy every cycle when the input keeps up
module surf_reducer (
    input  logic                 aclk,
    input  logic                 arst_n,
    axis_if.sink                 ev64,
    output surf_pkg::ev_word_t   m_tdata,
    output logic                 m_tvalid,
    input  logic                 m_tready,
    output logic                 m_tlast
);

    import surf_pkg::*;

    logic     full_q;
    logic     sel_q;
    logic     last_q;
    ev_beat_u beat_q;
    logic     take;
    logic     accept;
    logic     word_done;

    // room for a beat when empty, or when half 1 is leaving now
    assign take      = !full_q || (m_tready && sel_q);
    assign accept    = ev64.tvalid && take;
    assign word_done = full_q && m_tready;

    assign ev64.tready = take;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
            sel_q  <= 1'b0;
        end else if (accept) begin
            // a fresh beat always starts on half 0
            full_q <= 1'b1;
            sel_q  <= 1'b0;
        end else if (word_done) begin
            if (sel_q) begin
                full_q <= 1'b0;
                sel_q  <= 1'b0;
            end else begin
                sel_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            beat_q <= ev64.tdata;
            last_q <= ev64.tlast;
        end
    end

    // read back through the half view
    assign m_tdata  = beat_q.halves[sel_q];
    assign m_tvalid = full_q;

    // the packet marker belongs to the second word only
    assign m_tlast = last_q && sel_q;

    // the marker can only come up right after a half 0 word has left
    property p_last_on_half1;
        @(posedge aclk) disable iff (!arst_n)
        $rose(m_tlast) |-> $past(m_tvalid && m_tready && !m_tlast);
    endproperty

    a_last_on_half1 : assert property (p_last_on_half1)
        else $error("m_tlast raised with half 0");

    property p_word_held;
        @(posedge aclk) disable iff (!arst_n)
        m_tvalid && !m_tready |=>
            m_tvalid && $stable(m_tdata) && $stable(m_tlast);
    endproperty

    a_word_held : assert property (p_word_held)
        else $error("output word changed while stalled");

endmodule

// ==== surf_merger.f ====
+incdir+src
src/surf_pkg.sv
src/axis_if.sv
src/surf_combiner.sv
src/surf_reducer.sv
src/surf_merger.sv
tests/surf_merger_tb.sv

// ==== tests/surf_merger_tb.sv ====
`timescale 1ns/1ps
`include "surf_consts.svh"

module surf_merger_tb;

    import surf_pkg::*;

    localparam int n_fixed      = 8;
    localparam int n_entries    = 32;
    localparam int max_delay    = 6;
    localparam int stall_allow  = 16;
    localparam int reset_cycles = 4;
    localparam int margin       = 60;
    localparam int cycle_limit  =
        n_entries * (max_delay + 2 + stall_allow) + reset_cycles + margin;

    // one row of stimulus, byte i and delay nibble i belong to sector i
    typedef struct {
        string                           name;
        surf_byte_t [`SURF_LANES-1:0]    data;
        logic                            last0;
        logic       [`SURF_LANES-1:1]    last_other;
        logic       [4*`SURF_LANES-1:0]  delay;
        logic                            stall;
    } stim_t;

    logic                              aclk;
    logic                              arst_n;
    surf_byte_t [`SURF_LANES-1:0]      s_tdata;
    logic       [`SURF_LANES-1:0]      s_tvalid;
    logic       [`SURF_LANES-1:0]      s_tready;
    logic       [`SURF_LANES-1:0]      s_tlast;
    ev_word_t                          m_tdata;
    logic                              m_tvalid;
    logic                              m_tready;
    logic                              m_tlast;

    stim_t    stim [n_entries];
    integer   seed = 99;
    int       cycle = 0;
    int       mismatch_count = 0;
    int       other_count = 0;
    int       last_out_cycle = -10;
    bit       lat_armed = 0;

    // expected words in output order
    ev_word_t exp_word_q [$];
    logic     exp_last_q [$];
    int       exp_idx_q [$];
    int       exp_acc_q [$];
    bit       exp_half_q [$];

    surf_merger i_dut (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // cycle count for latency checks and for the run limit
    always @(posedge aclk) begin
        cycle <= cycle + 1;
    end

    // guard against a hung run
    initial begin
        wait (cycle >= cycle_limit);
        $display("timeout after %0d cycles with %0d output words never seen",
                 cycle, exp_word_q.size());
        $display("Testbench failed");
        $finish;
    end

    task automatic check_word(input string name, input ev_word_t exp, input ev_word_t act);
        if (exp !== act) begin
            $display("Mismatch %s word: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s last: expected %b, actual %b", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s valid: expected %b, actual %b", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_ready(input string name, input logic [`SURF_LANES-1:0] exp,
                               input logic [`SURF_LANES-1:0] act);
        if (exp !== act) begin
            $display("Mismatch %s ready: expected %b, actual %b", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Mismatch %s cycle: expected %0d, actual %0d", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic set_entry(input int k, input string name, input logic [55:0] data,
                             input logic last0, input logic [5:0] last_other,
                             input logic [27:0] delay);
        stim[k].name       = name;
        stim[k].data       = data;
        stim[k].last0      = last0;
        stim[k].last_other = last_other;
        stim[k].delay      = delay;
        stim[k].stall      = 1'b0;
    endtask

    task automatic build_stim();
        int rnd;
        set_entry(0, "aligned",        56'h77_66_55_44_33_22_11, 1'b0, 6'h00, 28'h0000000);
        set_entry(1, "last_high",      56'h07_06_05_04_03_02_01, 1'b1, 6'h00, 28'h0000000);
        set_entry(2, "skew_up",        56'hf6_e5_d4_c3_b2_a1_90, 1'b0, 6'h00, 28'h6543210);
        set_entry(3, "skew_down",      56'h0f_1e_2d_3c_4b_5a_69, 1'b1, 6'h00, 28'h0123456);
        set_entry(4, "other_last",     56'hde_ad_be_ef_ca_fe_42, 1'b0, 6'h3f, 28'h2020202);
        set_entry(5, "lane6_late",     56'h80_00_ff_01_fe_02_fd, 1'b1, 6'h15, 28'h6000000);
        set_entry(6, "lane0_late",     56'h5a_a5_5a_a5_5a_a5_5a, 1'b0, 6'h2a, 28'h0000006);
        set_entry(7, "back_to_back",   56'h12_34_56_78_9a_bc_de, 1'b1, 6'h00, 28'h0000000);
        // the rest run under random back-pressure
        for (int k = n_fixed; k < n_entries; k++) begin
            stim[k].name = $sformatf("random_%0d", k);
            rnd = $random(seed);
            stim[k].data[3:0] = rnd;
            rnd = $random(seed);
            stim[k].data[6:4] = rnd[23:0];
            stim[k].last0 = rnd[31];
            rnd = $random(seed);
            stim[k].last_other = rnd[5:0];
            for (int i = 0; i < `SURF_LANES; i++) begin
                rnd = $random(seed);
                stim[k].delay[4*i +: 4] = 4'(rnd[15:0] % (max_delay + 1));
            end
            stim[k].stall = 1'b1;
        end
    endtask

    // m_tready is known to be high for this beat and the three after it
    function automatic bit quiet(input int k);
        bit q;
        q = 1'b1;
        for (int j = k; j < k + 4 && j < n_entries; j++) begin
            if (stim[j].stall) begin
                q = 1'b0;
            end
        end
        return q;
    endfunction

    task automatic push_expected(input int k);
        // half 0 is sectors 3..0, half 1 is the zero lane above sectors 6..4
        exp_word_q.push_back({stim[k].data[3], stim[k].data[2],
                              stim[k].data[1], stim[k].data[0]});
        exp_last_q.push_back(1'b0);
        exp_idx_q.push_back(k);
        exp_acc_q.push_back(cycle);
        exp_half_q.push_back(1'b0);
        exp_word_q.push_back({8'h00, stim[k].data[6], stim[k].data[5], stim[k].data[4]});
        exp_last_q.push_back(stim[k].last0);
        exp_idx_q.push_back(k);
        exp_acc_q.push_back(cycle);
        exp_half_q.push_back(1'b1);
    endtask

    task automatic apply_entry(input int k);
        int                      cyc;
        bit                      done;
        int                      rnd;
        logic [`SURF_LANES-1:0]  vld;
        cyc  = 0;
        done = 1'b0;
        s_tdata <= stim[k].data;
        s_tlast <= {stim[k].last_other, stim[k].last0};
        while (!done) begin
            for (int i = 0; i < `SURF_LANES; i++) begin
                vld[i] = (cyc >= int'(stim[k].delay[4*i +: 4]));
            end
            s_tvalid <= vld;
            if (stim[k].stall) begin
                rnd = $random(seed);
                m_tready <= rnd[0];
            end else begin
                m_tready <= 1'b1;
            end
            @(posedge aclk);
            cyc++;
            if (&s_tvalid) begin
                // all lanes valid, so any ready must be the full vector
                if (s_tready != '0) begin
                    check_ready(stim[k].name, '1, s_tready);
                    push_expected(k);
                    done = 1'b1;
                end
            end else begin
                check_ready(stim[k].name, '0, s_tready);
            end
        end
    endtask

    always @(posedge aclk) begin : output_monitor
        ev_word_t want_word;
        logic     want_last;
        int       idx;
        int       acc;
        bit       half;
        if (arst_n && m_tvalid && m_tready) begin
            if (exp_word_q.size() == 0) begin
                $display("output word %h arrived when no word was expected", m_tdata);
                other_count++;
            end else begin
                want_word = exp_word_q.pop_front();
                want_last = exp_last_q.pop_front();
                idx       = exp_idx_q.pop_front();
                acc       = exp_acc_q.pop_front();
                half      = exp_half_q.pop_front();
                check_word(stim[idx].name, want_word, m_tdata);
                check_last(stim[idx].name, want_last, m_tlast);
                // latency is only fixed when the path was idle at the handshake
                if (!half) begin
                    lat_armed = quiet(idx) && (last_out_cycle <= acc + 1);
                    if (lat_armed) begin
                        check_latency(stim[idx].name, acc + 2, cycle);
                    end
                end else if (lat_armed) begin
                    check_latency(stim[idx].name, acc + 3, cycle);
                end
                last_out_cycle = cycle;
            end
        end
    end

    initial begin
        arst_n   = 1'b0;
        s_tdata  = '0;
        s_tvalid = '0;
        s_tlast  = '0;
        m_tready = 1'b0;
        build_stim();

        repeat (reset_cycles) begin
            @(posedge aclk);
            check_ready("in_reset", '0, s_tready);
        end
        arst_n <= 1'b1;
        m_tready <= 1'b1;

        // nothing valid yet, so both sides stay quiet
        repeat (3) begin
            @(posedge aclk);
            check_ready("idle_after_reset", '0, s_tready);
            check_valid("idle_after_reset", 1'b0, m_tvalid);
        end

        for (int k = 0; k < n_entries; k++) begin
            apply_entry(k);
        end
        s_tvalid <= '0;
        m_tready <= 1'b1;

        while (exp_word_q.size() != 0) begin
            @(posedge aclk);
        end
        // a few more cycles so any extra word shows up in the monitor
        repeat (6) @(posedge aclk);

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
